// ==== ahbmx_pkg.sv ====
// ------------------------------------------------------------------
// ahbmx shared definitions
// Bus widths, AHB-Lite encodings, bundled bus types and SRAM size
// ------------------------------------------------------------------
package ahbmx_pkg;

  // ------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------
  localparam int ADDR_W    = 32;   // HADDR width
  localparam int DATA_W    = 32;   // HWDATA / HRDATA width
  localparam int MEM_WORDS = 64;   // SRAM depth in words

  // ------------------------------------------------------------------
  // AHB-Lite encodings
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // AHB-Lite only has the two responses
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // Address phase bundle, HSEL HADDR HTRANS HWRITE HSIZE
  typedef struct packed {
    logic              sel;
    logic [ADDR_W-1:0] addr;
    htrans_e           trans;
    logic              write;
    hsize_e            size;
  } ahb_addr_t;

  // Response bundle, HREADYOUT and HRESP
  typedef struct packed {
    logic   readyout;
    hresp_e resp;
  } ahb_resp_t;

  // Slave data phase tracker in the output stage
  typedef enum logic {
    IDLE_PHASE = 1'b0,
    DATA_PHASE = 1'b1
  } arb_state_e;

endpackage

// ==== ahbmx_in_stage.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------------
// ahbmx input stage
// Holds an address phase the arbiter cannot take, answers its master
// ------------------------------------------------------------------
module ahbmx_in_stage
(
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  ahbmx_pkg::ahb_addr_t bus_in,        // Live address phase from master
  input  logic                 hready,        // Master side HREADY
  input  logic                 grant_active,  // Port owns slave address phase
  input  ahbmx_pkg::ahb_resp_t slv_resp,      // Routed slave response
  output ahbmx_pkg::ahb_addr_t fwd,           // Address phase to arbiter
  output logic                 req,           // Arbitration request
  output ahbmx_pkg::ahb_resp_t master_resp    // HREADYOUT and HRESP to master
);

  // ------------------------------------------------------------------
  // Internal signals
  // ------------------------------------------------------------------
  logic                 addr_valid;    // NONSEQ or SEQ to this port
  logic                 load_reg;      // Address phase accepted from master
  logic                 take;          // Slave takes our address this cycle
  logic                 pend_q;        // Holding register in use
  logic                 data_valid_q;  // Master is in a data phase
  ahbmx_pkg::ahb_addr_t held_q;        // Holding register

  assign addr_valid = bus_in.sel & bus_in.trans[1];
  assign load_reg   = addr_valid & hready;

  // Granted and slave ready, so the address phase completes on this edge
  assign take = grant_active & slv_resp.readyout;

  // ------------------------------------------------------------------
  // Holding register
  // ------------------------------------------------------------------
  // Captured on every accepted address phase, only used while pend_q
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      held_q <= bus_in;
    end
  end

  // Pending flag
  // Set when an accepted transfer cannot go to the slave at once,
  // cleared on the edge the slave finally samples it
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      pend_q <= 1'b0;
    end
    else if (take)
    begin
      pend_q <= 1'b0;    // Direct or held transfer taken
    end
    else if (load_reg)
    begin
      pend_q <= 1'b1;    // Lost arbitration or slave busy
    end
  end

  // Data phase flag, follows the master's own HREADY
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_valid_q <= 1'b0;
    end
    else if (hready)
    begin
      data_valid_q <= addr_valid;
    end
  end

  // ------------------------------------------------------------------
  // Forwarding mux and request
  // ------------------------------------------------------------------
  always_comb
  begin
    if (pend_q)
    begin
      fwd       = held_q;
      fwd.sel   = 1'b1;
      fwd.trans = ahbmx_pkg::NONSEQ;   // Held transfer always restarts
    end
    else
    begin
      fwd = bus_in;                    // Straight through
    end
  end

  assign req = load_reg | pend_q;

  // ------------------------------------------------------------------
  // HREADYOUT and HRESP
  // ------------------------------------------------------------------
  always_comb
  begin
    if (!data_valid_q)
    begin
      master_resp.readyout = 1'b1;     // No transfer outstanding
      master_resp.resp     = ahbmx_pkg::OKAY;
    end
    else if (pend_q)
    begin
      master_resp.readyout = 1'b0;     // Stall while waiting for grant
      master_resp.resp     = ahbmx_pkg::OKAY;
    end
    else
    begin
      master_resp = slv_resp;
    end
  end

endmodule

// ==== ahbmx_out_stage.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------------
// ahbmx output stage
// Round-robin arbiter and mux from two input stages to one slave
// ------------------------------------------------------------------
module ahbmx_out_stage
(
  input  logic                           HCLK,
  input  logic                           HRESETn,
  input  ahbmx_pkg::ahb_addr_t           fwd0,       // Port 0 address phase
  input  ahbmx_pkg::ahb_addr_t           fwd1,       // Port 1 address phase
  input  logic                           req0,
  input  logic                           req1,
  input  logic [ahbmx_pkg::DATA_W-1:0]   wdata0,
  input  logic [ahbmx_pkg::DATA_W-1:0]   wdata1,
  input  ahbmx_pkg::ahb_resp_t           slv_resp,   // From SRAM
  input  logic [ahbmx_pkg::DATA_W-1:0]   slv_rdata,
  output logic                           active0,    // Port 0 owns address phase
  output logic                           active1,    // Port 1 owns address phase
  output ahbmx_pkg::ahb_addr_t           slv_addr,
  output logic [ahbmx_pkg::DATA_W-1:0]   slv_wdata,
  output ahbmx_pkg::ahb_resp_t           resp0,
  output ahbmx_pkg::ahb_resp_t           resp1,
  output logic [ahbmx_pkg::DATA_W-1:0]   rdata       // To both masters
);

  logic                  slv_ready;   // Slave HREADY
  logic                  pick;        // Round-robin winner
  logic                  grant;       // Address phase owner
  logic                  grant_q;     // Owner frozen over wait states
  logic                  last_q;      // Port served last
  logic                  req_g;       // Request of granted port
  logic                  accept;      // Slave samples an address phase
  ahbmx_pkg::ahb_addr_t  fwd_g;
  ahbmx_pkg::arb_state_e dp_state_q;  // Slave data phase in progress
  logic                  dp_owner_q;  // Port owning that data phase

  assign slv_ready = slv_resp.readyout;

  // ------------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------------
  // Ties go to the port not served last and an idle bus parks on the owner
  always_comb
  begin
    if (req0 && req1)
      pick = ~last_q;
    else if (req0)
      pick = 1'b0;
    else if (req1)
      pick = 1'b1;
    else
      pick = grant_q;
  end

  // New owner only in a ready cycle and without an extra arbitration cycle
  assign grant   = slv_ready ? pick : grant_q;
  assign active0 = ~grant;
  assign active1 = grant;

  // Slave address phase from the owner and gated by its request
  assign fwd_g = grant ? fwd1 : fwd0;
  assign req_g = grant ? req1 : req0;

  always_comb
  begin
    slv_addr     = fwd_g;
    slv_addr.sel = fwd_g.sel & req_g;
  end

  assign accept = slv_addr.sel & slv_addr.trans[1] & slv_ready;

  // ------------------------------------------------------------------
  // Grant and data phase registers
  // ------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q    <= 1'b0;
      last_q     <= 1'b1;                   // Port 0 wins the first tie
      dp_state_q <= ahbmx_pkg::IDLE_PHASE;
      dp_owner_q <= 1'b0;
    end
    else if (slv_ready)
    begin
      grant_q <= grant;
      if (accept)
      begin
        last_q     <= grant;
        dp_state_q <= ahbmx_pkg::DATA_PHASE;
        dp_owner_q <= grant;
      end
      else
      begin
        dp_state_q <= ahbmx_pkg::IDLE_PHASE;
      end
    end
  end

  // ------------------------------------------------------------------
  // Data and response routing
  // ------------------------------------------------------------------
  assign slv_wdata = dp_owner_q ? wdata1 : wdata0;   // Write data one cycle later
  assign rdata     = slv_rdata;

  // Slave response goes to the data phase owner and the other port sees idle OKAY
  assign resp0 = (dp_state_q == ahbmx_pkg::DATA_PHASE && !dp_owner_q)
                 ? slv_resp : ahbmx_pkg::ahb_resp_t'{1'b1, ahbmx_pkg::OKAY};
  assign resp1 = (dp_state_q == ahbmx_pkg::DATA_PHASE && dp_owner_q)
                 ? slv_resp : ahbmx_pkg::ahb_resp_t'{1'b1, ahbmx_pkg::OKAY};

endmodule

// ==== ahbmx_sram.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------------
// ahbmx SRAM slave, one wait state, ERROR beyond MEM_WORDS
// ------------------------------------------------------------------
module ahbmx_sram
(
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  ahbmx_pkg::ahb_addr_t          bus,
  input  logic                          hready,   // Own readyout fed back
  input  logic [ahbmx_pkg::DATA_W-1:0]  wdata,
  output ahbmx_pkg::ahb_resp_t          resp,
  output logic [ahbmx_pkg::DATA_W-1:0]  rdata
);

  logic [ahbmx_pkg::DATA_W-1:0]             mem [ahbmx_pkg::MEM_WORDS];
  logic [$clog2(ahbmx_pkg::MEM_WORDS)-1:0]  word_q;   // Captured word index
  logic [ahbmx_pkg::DATA_W/8-1:0]           be;       // Byte lanes of bus
  logic [ahbmx_pkg::DATA_W/8-1:0]           be_q;
  logic                                     write_q;
  logic                                     accept;
  logic                                     in_range;
  logic                                     busy_q;   // Wait state cycle
  logic                                     done_q;   // Last data cycle
  logic                                     err_q;

  assign accept   = hready & bus.sel & bus.trans[1];
  assign in_range = bus.addr[ahbmx_pkg::ADDR_W-1:2] < ahbmx_pkg::MEM_WORDS;

  // Byte lanes from HSIZE and low address bits
  always_comb
  begin
    case (bus.size)
      ahbmx_pkg::BYTE: be = 4'b0001 << bus.addr[1:0];
      ahbmx_pkg::HALF: be = bus.addr[1] ? 4'b1100 : 4'b0011;
      default:         be = 4'b1111;
    endcase
  end

  // ------------------------------------------------------------------
  // Memory and data phase payload
  // ------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      word_q  <= bus.addr[2 +: $clog2(ahbmx_pkg::MEM_WORDS)];
      be_q    <= be;
      write_q <= bus.write;
    end
    if (busy_q)
      rdata <= mem[word_q];              // Ready for the last data cycle
    if (done_q && write_q && !err_q)
    begin
      for (int b = 0; b < ahbmx_pkg::DATA_W/8; b++)
      begin
        if (be_q[b])
          mem[word_q][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

  // Two cycle data phase sequencer
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      busy_q <= accept;
      done_q <= busy_q;
      if (accept)
        err_q <= ~in_range;
    end
  end

  assign resp.readyout = ~busy_q;
  assign resp.resp     = (err_q && (busy_q || done_q)) ? ahbmx_pkg::ERROR
                                                       : ahbmx_pkg::OKAY;

endmodule

// ==== ahbmx_top.sv ====
`timescale 1ns/1ns
// ------------------------------------------------------------------
// ahbmx top, two AHB-Lite masters sharing one SRAM slave
// ------------------------------------------------------------------
module ahbmx_top
(
  input  logic                          HCLK,
  input  logic                          HRESETn,
  // Master port 0
  input  ahbmx_pkg::ahb_addr_t          m0_addr,
  input  logic [ahbmx_pkg::DATA_W-1:0]  m0_wdata,
  input  logic                          m0_hready,
  output ahbmx_pkg::ahb_resp_t          m0_resp,
  output logic [ahbmx_pkg::DATA_W-1:0]  m0_rdata,
  // Master port 1
  input  ahbmx_pkg::ahb_addr_t          m1_addr,
  input  logic [ahbmx_pkg::DATA_W-1:0]  m1_wdata,
  input  logic                          m1_hready,
  output ahbmx_pkg::ahb_resp_t          m1_resp,
  output logic [ahbmx_pkg::DATA_W-1:0]  m1_rdata
);

  // ------------------------------------------------------------------
  // Interconnect wires
  // ------------------------------------------------------------------
  ahbmx_pkg::ahb_addr_t          fwd0;
  ahbmx_pkg::ahb_addr_t          fwd1;
  logic                          req0;
  logic                          req1;
  logic                          active0;
  logic                          active1;
  ahbmx_pkg::ahb_resp_t          resp0;      // Routed to input stage 0
  ahbmx_pkg::ahb_resp_t          resp1;      // Routed to input stage 1
  ahbmx_pkg::ahb_addr_t          slv_addr;
  logic [ahbmx_pkg::DATA_W-1:0]  slv_wdata;
  ahbmx_pkg::ahb_resp_t          slv_resp;
  logic [ahbmx_pkg::DATA_W-1:0]  slv_rdata;
  logic [ahbmx_pkg::DATA_W-1:0]  rdata;

  ahbmx_in_stage u_in0 (
    .HCLK(HCLK), .HRESETn(HRESETn), .bus_in(m0_addr), .hready(m0_hready),
    .grant_active(active0), .slv_resp(resp0),
    .fwd(fwd0), .req(req0), .master_resp(m0_resp)
  );

  ahbmx_in_stage u_in1 (
    .HCLK(HCLK), .HRESETn(HRESETn), .bus_in(m1_addr), .hready(m1_hready),
    .grant_active(active1), .slv_resp(resp1),
    .fwd(fwd1), .req(req1), .master_resp(m1_resp)
  );

  ahbmx_out_stage u_out (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .fwd0(fwd0), .fwd1(fwd1), .req0(req0), .req1(req1),
    .wdata0(m0_wdata), .wdata1(m1_wdata),
    .slv_resp(slv_resp), .slv_rdata(slv_rdata),
    .active0(active0), .active1(active1),
    .slv_addr(slv_addr), .slv_wdata(slv_wdata),
    .resp0(resp0), .resp1(resp1), .rdata(rdata)
  );

  // Slave HREADY is its own readyout
  ahbmx_sram u_sram (
    .HCLK(HCLK), .HRESETn(HRESETn), .bus(slv_addr), .hready(slv_resp.readyout),
    .wdata(slv_wdata), .resp(slv_resp), .rdata(slv_rdata)
  );

  // Read data shared, each master samples it on its own HREADYOUT
  assign m0_rdata = rdata;
  assign m1_rdata = rdata;

endmodule

// ==== tb_ahbmx.sv ====
`timescale 1ns/1ns
// ----------------------------------------------------------------------
// ahbmx testbench
// Table driven traffic on both masters, checked against a memory model
// ----------------------------------------------------------------------
module tb_ahbmx;

  localparam int NUM_ROWS    = 21;
  localparam int CYC_PER_ROW = 40;
  localparam int TIMEOUT_NS  = (NUM_ROWS * CYC_PER_ROW + 10) * 10;
  localparam int SEED        = 21;
  localparam int HI_WORD     = 32;   // Port 1 word offset in contention rows

  typedef struct packed {
    logic [1:0]        mask;   // Bit 0 m0, bit 1 m1
    logic              wr;
    logic              skew;   // One port starts a cycle early
    logic [7:0]        word;
    ahbmx_pkg::hsize_e size;
    logic [1:0]        off;    // Byte offset in the word
    ahbmx_pkg::hresp_e exp;
  } row_t;

  logic                         HCLK;
  logic                         HRESETn;
  ahbmx_pkg::ahb_addr_t         m_addr    [2];
  logic [ahbmx_pkg::DATA_W-1:0] m_wdata   [2];
  ahbmx_pkg::ahb_resp_t         m_resp    [2];
  logic [ahbmx_pkg::DATA_W-1:0] m_rdata   [2];
  // Per port results of the last transfer
  ahbmx_pkg::hresp_e            got_resp  [2];
  ahbmx_pkg::ahb_resp_t         first_cyc [2];   // First data phase cycle
  logic [ahbmx_pkg::DATA_W-1:0] got_rdata [2];
  int                           phase_len [2];   // Data phase cycles
  time                          done_at   [2];
  logic [ahbmx_pkg::DATA_W-1:0] model     [ahbmx_pkg::MEM_WORDS];
  row_t                         rows      [NUM_ROWS];
  int                           errors;
  int                           checks;
  int                           last_served;

  // Each master's HREADY is its own HREADYOUT
  ahbmx_top UUT (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .m0_addr(m_addr[0]), .m0_wdata(m_wdata[0]), .m0_hready(m_resp[0].readyout),
    .m0_resp(m_resp[0]), .m0_rdata(m_rdata[0]),
    .m1_addr(m_addr[1]), .m1_wdata(m_wdata[1]), .m1_hready(m_resp[1].readyout),
    .m1_resp(m_resp[1]), .m1_rdata(m_rdata[1])
  );

  always #5 HCLK = ~HCLK;   // 10 ns period

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Byte lanes of an AHB transfer, aligned to its size
  function automatic logic [3:0] lanes(input ahbmx_pkg::hsize_e size, input logic [1:0] off);
    int         nbytes;
    int         first;
    logic [3:0] m;
    nbytes = 1 << size;
    first  = off & ~(nbytes - 1);
    m      = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (b >= first && b < first + nbytes)
        m[b] = 1'b1;
    end
    return m;
  endfunction

  // One AHB-Lite transfer on port p, address phase then data phase
  task automatic run_port(input int p, input int delay, input logic wr, input int word,
                          input ahbmx_pkg::hsize_e size, input logic [1:0] off,
                          input logic [31:0] wd);
    ahbmx_pkg::ahb_addr_t a;
    a       = '0;
    a.sel   = 1'b1;
    a.addr  = word * 4 + off;
    a.trans = ahbmx_pkg::NONSEQ;
    a.write = wr;
    a.size  = size;
    repeat (delay) @(posedge HCLK);
    @(posedge HCLK);
    m_addr[p] <= a;
    @(negedge HCLK);
    while (!m_resp[p].readyout)          // Accepted on the next HREADY edge
      @(negedge HCLK);
    @(posedge HCLK);
    m_addr[p]  <= '0;                    // Back to IDLE
    m_wdata[p] <= wd;
    @(negedge HCLK);
    first_cyc[p] = m_resp[p];
    phase_len[p] = 1;
    while (!m_resp[p].readyout)
    begin
      @(negedge HCLK);
      phase_len[p]++;
    end
    got_resp[p]  = m_resp[p].resp;
    got_rdata[p] = m_rdata[p];
    done_at[p]   = $time;
  endtask

  task automatic load_table();
    rows[0]  = '{2'b01, 1'b1, 1'b0, 8'd6,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[1]  = '{2'b01, 1'b0, 1'b0, 8'd6,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[2]  = '{2'b10, 1'b1, 1'b0, 8'd5,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[3]  = '{2'b10, 1'b0, 1'b0, 8'd5,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[4]  = '{2'b11, 1'b1, 1'b0, 8'd8,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[5]  = '{2'b11, 1'b0, 1'b0, 8'd8,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[6]  = '{2'b01, 1'b0, 1'b0, 8'd6,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[7]  = '{2'b11, 1'b1, 1'b0, 8'd10, ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[8]  = '{2'b10, 1'b0, 1'b0, 8'd5,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[9]  = '{2'b11, 1'b0, 1'b0, 8'd10, ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[10] = '{2'b11, 1'b1, 1'b1, 8'd12, ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[11] = '{2'b11, 1'b0, 1'b1, 8'd12, ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[12] = '{2'b01, 1'b1, 1'b0, 8'd70, ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::ERROR};
    rows[13] = '{2'b10, 1'b0, 1'b0, 8'd64, ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::ERROR};
    rows[14] = '{2'b01, 1'b0, 1'b0, 8'd6,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[15] = '{2'b01, 1'b1, 1'b0, 8'd6,  ahbmx_pkg::BYTE, 2'd1, ahbmx_pkg::OKAY};
    rows[16] = '{2'b10, 1'b1, 1'b0, 8'd5,  ahbmx_pkg::HALF, 2'd2, ahbmx_pkg::OKAY};
    rows[17] = '{2'b01, 1'b0, 1'b0, 8'd6,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[18] = '{2'b10, 1'b0, 1'b0, 8'd5,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
    rows[19] = '{2'b11, 1'b1, 1'b1, 8'd8,  ahbmx_pkg::HALF, 2'd0, ahbmx_pkg::OKAY};
    rows[20] = '{2'b11, 1'b0, 1'b0, 8'd8,  ahbmx_pkg::WORD, 2'd0, ahbmx_pkg::OKAY};
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    row_t        r;
    int          w  [2];
    logic [31:0] wd [2];
    int          lead;
    int          first_p;
    int          exp_first;
    logic [3:0]  m;
    void'($urandom(SEED));
    errors      = 0;
    checks      = 0;
    last_served = 1;   // Port 0 takes a tie before any transfer
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    for (int p = 0; p < 2; p++)
    begin
      m_addr[p]  = '0;
      m_wdata[p] = '0;
    end
    load_table();
    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);
    for (int p = 0; p < 2; p++)
    begin
      check($sformatf("reset m%0d readyout", p), m_resp[p].readyout, 1'b1);
      check($sformatf("reset m%0d response", p), m_resp[p].resp, ahbmx_pkg::OKAY);
    end
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      r     = rows[i];
      lead  = $urandom % 2;                 // Early port of a skewed row
      w[0]  = r.word;
      w[1]  = (r.mask == 2'b11) ? r.word + HI_WORD : r.word;
      wd[0] = $urandom;
      wd[1] = $urandom;
      fork
        if (r.mask[0])
          run_port(0, (r.skew && lead == 1) ? 1 : 0, r.wr, w[0], r.size, r.off, wd[0]);
        if (r.mask[1])
          run_port(1, (r.skew && lead == 0) ? 1 : 0, r.wr, w[1], r.size, r.off, wd[1]);
      join
      for (int p = 0; p < 2; p++)
      begin
        if (r.mask[p])
        begin
          check($sformatf("row %0d m%0d response", i, p), got_resp[p], r.exp);
          if (r.exp == ahbmx_pkg::ERROR)
          begin
            check($sformatf("row %0d first cycle readyout", i), first_cyc[p].readyout, 1'b0);
            check($sformatf("row %0d first cycle response", i), first_cyc[p].resp, r.exp);
            check($sformatf("row %0d error length", i), phase_len[p], 2);
          end
          else if (r.wr && got_resp[p] == ahbmx_pkg::OKAY)
          begin
            m = lanes(r.size, r.off);
            for (int b = 0; b < 4; b++)
            begin
              if (m[b])
                model[w[p]][b*8 +: 8] = wd[p][b*8 +: 8];
            end
          end
          else if (!r.wr)
            check($sformatf("row %0d m%0d read data", i, p), got_rdata[p], model[w[p]]);
        end
      end
      // Arbitration order and wait states
      if (r.mask == 2'b11)
      begin
        exp_first = r.skew ? lead : (last_served ^ 1);
        first_p   = (done_at[0] < done_at[1]) ? 0 : 1;
        check($sformatf("row %0d ports finish apart", i), done_at[0] != done_at[1], 1'b1);
        check($sformatf("row %0d first port", i), first_p, exp_first);
        check($sformatf("row %0d winner length", i), phase_len[first_p], 2);
        check($sformatf("row %0d loser waits longer", i),
              phase_len[first_p ^ 1] > phase_len[first_p], 1'b1);
        last_served = exp_first ^ 1;
      end
      else
      begin
        last_served = r.mask[1];
        if (r.exp == ahbmx_pkg::OKAY)
          check($sformatf("row %0d data phase length", i), phase_len[r.mask[1]], 2);
      end
      $display("row %0d mask %b %s done, %0d errors so far", i, r.mask,
               r.wr ? "write" : "read", errors);
    end
    $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // Watchdog, sized from the table length
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout, the table did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== ahbmx.f ====
ahbmx_pkg.sv
ahbmx_in_stage.sv
ahbmx_out_stage.sv
ahbmx_sram.sv
ahbmx_top.sv
tb_ahbmx.sv
